// ==== rv3_core_params.svh ====
/*
 * rv3 core build constants.
 * Entry address, data width and register count shared across the core.
 */
`ifndef RV3_CORE_PARAMS_SVH
`define RV3_CORE_PARAMS_SVH

// Address of the first fetch after reset.
// Must stay word aligned.
`define RV3_ENTRY_PC 32'h0000_0100

// Width of a data word.
`define RV3_XLEN 32

// Number of architectural integer registers.
// Register x0 is counted but never written.
`define RV3_NREGS 32

// Only aligned 32-bit fetch is supported.
// The PC always advances by one word.

`endif

// ==== rv3_pkg.sv ====
/*
 * rv3 core types.
 * Words, addresses, register numbers and the decoded operation encodings.
 */
`include "rv3_core_params.svh"

package rv3_pkg;

    // One data word.
    typedef logic [`RV3_XLEN-1:0] word_t;

    // Instruction address, low two bits always zero.
    typedef logic [31:0] pc_t;

    // Architectural register number.
    typedef logic [$clog2(`RV3_NREGS)-1:0] reg_idx_t;

    // Major opcodes handled by the core.
    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        STORE  = 7'b0100011
    } opcode_e;

    // ALU function, {funct7[5], funct3} for the RV32I operations.
    typedef enum logic [3:0] {
        ALU_ADD    = 4'b0000,
        ALU_SLL    = 4'b0001,
        ALU_SLT    = 4'b0010,
        ALU_SLTU   = 4'b0011,
        ALU_XOR    = 4'b0100,
        ALU_SRL    = 4'b0101,
        ALU_OR     = 4'b0110,
        ALU_AND    = 4'b0111,
        ALU_SUB    = 4'b1000,
        ALU_SRA    = 4'b1101,
        ALU_PASS_B = 4'b1111
    } alu_op_e;

    // Branch condition, same encoding as the branch funct3.
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } br_cond_e;

endpackage

// ==== rv3_fetch.sv ====
/*
 * rv3 fetch stage.
 * Keeps the PC and the unpredicted path, and loads the fetch/decode barrier.
 */
`timescale 1ns/100ps
`include "rv3_core_params.svh"

module rv3_fetch (
    input  logic            clk,
    input  logic            rst_latch,
    // Taken prediction from decode.
    input  logic            id_redirect,
    input  rv3_pkg::pc_t    id_target,
    // Unpredicted path of the decoded branch, zero when there is none.
    input  rv3_pkg::pc_t    id_alt_target,
    // Misprediction resolved in execute.
    input  logic            ex_branch_error,
    // Instruction memory, read in the same cycle.
    output rv3_pkg::pc_t    imem_addr,
    input  rv3_pkg::word_t  imem_rdata,
    // Fetch/decode barrier.
    output logic            if_id_valid,
    output rv3_pkg::pc_t    if_id_pc,
    output rv3_pkg::word_t  if_id_insn
);
    // Current fetch address.
    rv3_pkg::pc_t pc;
    // Path not taken by the last prediction.
    rv3_pkg::pc_t alt_pc;
    // Address fetched in the next cycle.
    rv3_pkg::pc_t next_pc;

    assign imem_addr = pc;

    // Misprediction wins over a decode redirect.
    always_comb begin
        if (ex_branch_error) begin
            next_pc = alt_pc;
        end else if (id_redirect) begin
            next_pc = id_target;
        end else begin
            next_pc = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_latch) begin
            pc     <= `RV3_ENTRY_PC;
            alt_pc <= `RV3_ENTRY_PC;
        end else begin
            pc <= next_pc;
            // Fall-through on a taken guess, target on a not-taken one.
            if (id_redirect || id_alt_target != '0) begin
                alt_pc <= id_alt_target;
            end
        end
    end

    // Word fetched behind a redirect is on the wrong path.
    always_ff @(posedge clk) begin
        if (rst_latch) begin
            if_id_valid <= 1'b0;
        end else begin
            if_id_valid <= !(id_redirect || ex_branch_error);
        end
    end

    // Barrier payload.
    always_ff @(posedge clk) begin
        if_id_pc   <= pc;
        if_id_insn <= imem_rdata;
    end

endmodule

// ==== rv3_regfile.sv ====
/*
 * rv3 integer register file.
 * Two combinational read ports, one write port, x0 reads as zero.
 */
`timescale 1ns/100ps
`include "rv3_core_params.svh"

module rv3_regfile (
    input  logic               clk,
    input  logic               rst_latch,
    // Read ports used by decode.
    input  rv3_pkg::reg_idx_t  rs1_idx,
    input  rv3_pkg::reg_idx_t  rs2_idx,
    output rv3_pkg::word_t     rs1_val,
    output rv3_pkg::word_t     rs2_val,
    // Writeback from execute.
    input  logic               wb_en,
    input  rv3_pkg::reg_idx_t  wb_rd,
    input  rv3_pkg::word_t     wb_data
);
    // Writable registers x1 and up.
    rv3_pkg::word_t regs [1:`RV3_NREGS-1];

    // Register x0 is not stored.
    assign rs1_val = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_val = (rs2_idx == '0) ? '0 : regs[rs2_idx];

    always_ff @(posedge clk) begin
        if (rst_latch) begin
            for (int i = 1; i < `RV3_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_rd != '0) begin
            // Writes to x0 are dropped.
            regs[wb_rd] <= wb_data;
        end
    end

endmodule

// ==== rv3_decode.sv ====
/*
 * rv3 decode stage.
 * Builds operands with forwarding, predicts branches, loads the decode/execute barrier.
 */
`timescale 1ns/100ps

module rv3_decode (
    input  logic               clk,
    input  logic               rst_latch,
    // Fetch/decode barrier.
    input  logic               if_id_valid,
    input  rv3_pkg::pc_t       if_id_pc,
    input  rv3_pkg::word_t     if_id_insn,
    // Register file read.
    output rv3_pkg::reg_idx_t  rs1_idx,
    output rv3_pkg::reg_idx_t  rs2_idx,
    input  rv3_pkg::word_t     rs1_val,
    input  rv3_pkg::word_t     rs2_val,
    // Execute result for forwarding.
    input  logic               ex_wb_en,
    input  rv3_pkg::reg_idx_t  ex_rd,
    input  rv3_pkg::word_t     ex_result,
    input  logic               ex_branch_error,
    // Prediction towards fetch.
    output logic               id_redirect,
    output rv3_pkg::pc_t       id_target,
    output rv3_pkg::pc_t       id_alt_target,
    // Decode/execute barrier.
    output logic               id_ex_valid,
    output rv3_pkg::alu_op_e   id_ex_op,
    output rv3_pkg::word_t     id_ex_lhs,
    output rv3_pkg::word_t     id_ex_rhs,
    output rv3_pkg::reg_idx_t  id_ex_rd,
    output logic               id_ex_is_branch,
    output rv3_pkg::br_cond_e  id_ex_cond,
    output logic               id_ex_predict,
    output logic               id_ex_is_store,
    output rv3_pkg::word_t     id_ex_offset,
    output rv3_pkg::word_t     id_ex_store_data
);
    rv3_pkg::opcode_e  opcode;
    logic [2:0]        funct3;
    rv3_pkg::word_t    imm_i, imm_s, imm_b, imm_u, imm_j;
    rv3_pkg::word_t    rs1_fwd, rs2_fwd;
    rv3_pkg::word_t    lhs, rhs;
    rv3_pkg::alu_op_e  op;
    logic              op_alt;
    logic              has_rd, is_branch, is_jal, taken;
    rv3_pkg::pc_t      fall_pc, br_target;

    assign opcode  = rv3_pkg::opcode_e'(if_id_insn[6:0]);
    assign funct3  = if_id_insn[14:12];
    assign rs1_idx = if_id_insn[19:15];
    assign rs2_idx = if_id_insn[24:20];

    // Sign-extended immediates.
    assign imm_i = {{20{if_id_insn[31]}}, if_id_insn[31:20]};
    assign imm_s = {{20{if_id_insn[31]}}, if_id_insn[31:25], if_id_insn[11:7]};
    assign imm_b = {{19{if_id_insn[31]}}, if_id_insn[31], if_id_insn[7],
                    if_id_insn[30:25], if_id_insn[11:8], 1'b0};
    assign imm_u = {if_id_insn[31:12], 12'b0};
    assign imm_j = {{11{if_id_insn[31]}}, if_id_insn[31], if_id_insn[19:12],
                    if_id_insn[20], if_id_insn[30:21], 1'b0};

    // Result still in execute replaces the stale register value.
    assign rs1_fwd = (ex_wb_en && ex_rd != '0 && ex_rd == rs1_idx) ? ex_result : rs1_val;
    assign rs2_fwd = (ex_wb_en && ex_rd != '0 && ex_rd == rs2_idx) ? ex_result : rs2_val;

    // Static prediction, backward taken.
    assign is_branch = if_id_valid && opcode == rv3_pkg::BRANCH;
    assign is_jal    = if_id_valid && opcode == rv3_pkg::JAL;
    assign taken     = is_jal || (is_branch && if_id_insn[31]);
    assign fall_pc   = if_id_pc + 32'd4;
    assign br_target = if_id_pc + imm_b;

    // Wrong-path instructions behind a misprediction do not steer fetch.
    assign id_redirect   = !ex_branch_error && taken;
    assign id_target     = is_jal ? if_id_pc + imm_j : br_target;
    assign id_alt_target = (!ex_branch_error && (is_branch || is_jal))
                           ? (taken ? fall_pc : br_target) : '0;

    // Bit 30 selects sub and sra only.
    assign op_alt = if_id_insn[30] &&
                    (funct3 == 3'b101 || (opcode == rv3_pkg::OP && funct3 == 3'b000));

    always_comb begin
        lhs    = rs1_fwd;
        rhs    = rs2_fwd;
        op     = rv3_pkg::ALU_ADD;
        has_rd = 1'b0;
        case (opcode)
            rv3_pkg::OP_IMM: begin
                rhs    = imm_i;
                op     = rv3_pkg::alu_op_e'({op_alt, funct3});
                has_rd = 1'b1;
            end
            rv3_pkg::OP: begin
                op     = rv3_pkg::alu_op_e'({op_alt, funct3});
                has_rd = 1'b1;
            end
            rv3_pkg::LUI: begin
                lhs    = '0;
                rhs    = imm_u;
                op     = rv3_pkg::ALU_PASS_B;
                has_rd = 1'b1;
            end
            rv3_pkg::JAL: begin
                // Link value is PC+4.
                lhs    = if_id_pc;
                rhs    = fall_pc;
                op     = rv3_pkg::ALU_PASS_B;
                has_rd = 1'b1;
            end
            default: begin
                // Branches and stores keep rs1 and rs2.
            end
        endcase
    end

    // Valid bit, cleared on a misprediction.
    always_ff @(posedge clk) begin
        if (rst_latch) begin
            id_ex_valid <= 1'b0;
        end else begin
            id_ex_valid <= if_id_valid && !ex_branch_error;
        end
    end

    // Barrier payload.
    always_ff @(posedge clk) begin
        id_ex_op         <= op;
        id_ex_lhs        <= lhs;
        id_ex_rhs        <= rhs;
        id_ex_rd         <= has_rd ? if_id_insn[11:7] : '0;
        id_ex_is_branch  <= opcode == rv3_pkg::BRANCH;
        id_ex_cond       <= rv3_pkg::br_cond_e'(funct3);
        id_ex_predict    <= if_id_insn[31];
        id_ex_is_store   <= opcode == rv3_pkg::STORE;
        id_ex_offset     <= imm_s;
        id_ex_store_data <= rs2_fwd;
    end

endmodule

// ==== rv3_execute.sv ====
/*
 * rv3 execute stage.
 * ALU, branch resolution, store strobe and writeback, all combinational.
 */
`timescale 1ns/100ps

module rv3_execute (
    // Decode/execute barrier.
    input  logic               id_ex_valid,
    input  rv3_pkg::alu_op_e   id_ex_op,
    input  rv3_pkg::word_t     id_ex_lhs,
    input  rv3_pkg::word_t     id_ex_rhs,
    input  rv3_pkg::reg_idx_t  id_ex_rd,
    input  logic               id_ex_is_branch,
    input  rv3_pkg::br_cond_e  id_ex_cond,
    input  logic               id_ex_predict,
    input  logic               id_ex_is_store,
    input  rv3_pkg::word_t     id_ex_offset,
    input  rv3_pkg::word_t     id_ex_store_data,
    // Data write port, one strobe per store.
    output logic               dmem_we,
    output rv3_pkg::word_t     dmem_addr,
    output rv3_pkg::word_t     dmem_wdata,
    // Writeback and forwarding.
    output logic               ex_wb_en,
    output rv3_pkg::reg_idx_t  ex_rd,
    output rv3_pkg::word_t     ex_result,
    // Branch went against its prediction.
    output logic               ex_branch_error
);
    rv3_pkg::word_t  alu_res;
    logic [4:0]      shamt;
    logic            br_taken;

    // Shift amount from the low bits of rhs.
    assign shamt = id_ex_rhs[4:0];

    always_comb begin
        case (id_ex_op)
            rv3_pkg::ALU_ADD:    alu_res = id_ex_lhs + id_ex_rhs;
            rv3_pkg::ALU_SUB:    alu_res = id_ex_lhs - id_ex_rhs;
            rv3_pkg::ALU_SLL:    alu_res = id_ex_lhs << shamt;
            rv3_pkg::ALU_SLT:    alu_res = rv3_pkg::word_t'($signed(id_ex_lhs) < $signed(id_ex_rhs));
            rv3_pkg::ALU_SLTU:   alu_res = rv3_pkg::word_t'(id_ex_lhs < id_ex_rhs);
            rv3_pkg::ALU_XOR:    alu_res = id_ex_lhs ^ id_ex_rhs;
            rv3_pkg::ALU_SRL:    alu_res = id_ex_lhs >> shamt;
            rv3_pkg::ALU_SRA:    alu_res = $signed(id_ex_lhs) >>> shamt;
            rv3_pkg::ALU_OR:     alu_res = id_ex_lhs | id_ex_rhs;
            rv3_pkg::ALU_AND:    alu_res = id_ex_lhs & id_ex_rhs;
            // LUI immediate or JAL link.
            rv3_pkg::ALU_PASS_B: alu_res = id_ex_rhs;
            default:             alu_res = '0;
        endcase
    end

    // Branch condition on rs1 and rs2.
    always_comb begin
        case (id_ex_cond)
            rv3_pkg::BR_EQ:  br_taken = id_ex_lhs == id_ex_rhs;
            rv3_pkg::BR_NE:  br_taken = id_ex_lhs != id_ex_rhs;
            rv3_pkg::BR_LT:  br_taken = $signed(id_ex_lhs) < $signed(id_ex_rhs);
            rv3_pkg::BR_GE:  br_taken = $signed(id_ex_lhs) >= $signed(id_ex_rhs);
            rv3_pkg::BR_LTU: br_taken = id_ex_lhs < id_ex_rhs;
            rv3_pkg::BR_GEU: br_taken = id_ex_lhs >= id_ex_rhs;
            // Reserved funct3 never branches.
            default:         br_taken = 1'b0;
        endcase
    end

    // Fetch reloads the alternate path on this.
    assign ex_branch_error = id_ex_valid && id_ex_is_branch && (br_taken != id_ex_predict);

    // Word store at rs1 plus offset.
    assign dmem_we    = id_ex_valid && id_ex_is_store;
    assign dmem_addr  = id_ex_lhs + id_ex_offset;
    assign dmem_wdata = id_ex_store_data;

    // Decode already zeroed rd for instructions without a result.
    assign ex_wb_en  = id_ex_valid && id_ex_rd != '0;
    assign ex_rd     = id_ex_rd;
    assign ex_result = alu_res;

endmodule

// ==== rv3_core.sv ====
/*
 * rv3 core top level.
 * Three-stage RV32I pipeline, fetch, decode and execute around one register file.
 */
`timescale 1ns/100ps

module rv3_core (
    input  logic            clk,
    input  logic            rst_latch,
    // Instruction memory, combinational read.
    output rv3_pkg::pc_t    imem_addr,
    input  rv3_pkg::word_t  imem_rdata,
    // Data write port.
    output logic            dmem_we,
    output rv3_pkg::word_t  dmem_addr,
    output rv3_pkg::word_t  dmem_wdata
);
    // Fetch/decode barrier.
    logic               if_id_valid;
    rv3_pkg::pc_t       if_id_pc;
    rv3_pkg::word_t     if_id_insn;

    // Prediction back to fetch.
    logic               id_redirect;
    rv3_pkg::pc_t       id_target;
    rv3_pkg::pc_t       id_alt_target;

    // Register file reads.
    rv3_pkg::reg_idx_t  rs1_idx;
    rv3_pkg::reg_idx_t  rs2_idx;
    rv3_pkg::word_t     rs1_val;
    rv3_pkg::word_t     rs2_val;

    // Decode/execute barrier.
    logic               id_ex_valid;
    rv3_pkg::alu_op_e   id_ex_op;
    rv3_pkg::word_t     id_ex_lhs;
    rv3_pkg::word_t     id_ex_rhs;
    rv3_pkg::reg_idx_t  id_ex_rd;
    logic               id_ex_is_branch;
    rv3_pkg::br_cond_e  id_ex_cond;
    logic               id_ex_predict;
    logic               id_ex_is_store;
    rv3_pkg::word_t     id_ex_offset;
    rv3_pkg::word_t     id_ex_store_data;

    // Execute results.
    logic               ex_wb_en;
    rv3_pkg::reg_idx_t  ex_rd;
    rv3_pkg::word_t     ex_result;
    logic               ex_branch_error;

    rv3_fetch u_fetch (
        .clk(clk), .rst_latch(rst_latch),
        .id_redirect(id_redirect), .id_target(id_target), .id_alt_target(id_alt_target),
        .ex_branch_error(ex_branch_error),
        .imem_addr(imem_addr), .imem_rdata(imem_rdata),
        .if_id_valid(if_id_valid), .if_id_pc(if_id_pc), .if_id_insn(if_id_insn)
    );

    rv3_regfile u_regfile (
        .clk(clk), .rst_latch(rst_latch),
        .rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .rs1_val(rs1_val), .rs2_val(rs2_val),
        .wb_en(ex_wb_en), .wb_rd(ex_rd), .wb_data(ex_result)
    );

    rv3_decode u_decode (
        .clk(clk), .rst_latch(rst_latch),
        .if_id_valid(if_id_valid), .if_id_pc(if_id_pc), .if_id_insn(if_id_insn),
        .rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .rs1_val(rs1_val), .rs2_val(rs2_val),
        .ex_wb_en(ex_wb_en), .ex_rd(ex_rd), .ex_result(ex_result),
        .ex_branch_error(ex_branch_error),
        .id_redirect(id_redirect), .id_target(id_target), .id_alt_target(id_alt_target),
        .id_ex_valid(id_ex_valid), .id_ex_op(id_ex_op),
        .id_ex_lhs(id_ex_lhs), .id_ex_rhs(id_ex_rhs), .id_ex_rd(id_ex_rd),
        .id_ex_is_branch(id_ex_is_branch), .id_ex_cond(id_ex_cond),
        .id_ex_predict(id_ex_predict), .id_ex_is_store(id_ex_is_store),
        .id_ex_offset(id_ex_offset), .id_ex_store_data(id_ex_store_data)
    );

    rv3_execute u_execute (
        .id_ex_valid(id_ex_valid), .id_ex_op(id_ex_op),
        .id_ex_lhs(id_ex_lhs), .id_ex_rhs(id_ex_rhs), .id_ex_rd(id_ex_rd),
        .id_ex_is_branch(id_ex_is_branch), .id_ex_cond(id_ex_cond),
        .id_ex_predict(id_ex_predict), .id_ex_is_store(id_ex_is_store),
        .id_ex_offset(id_ex_offset), .id_ex_store_data(id_ex_store_data),
        .dmem_we(dmem_we), .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
        .ex_wb_en(ex_wb_en), .ex_rd(ex_rd), .ex_result(ex_result),
        .ex_branch_error(ex_branch_error)
    );

endmodule

// ==== rv3_core_sva.sv ====
/*
 * Port-level assertions for the rv3 core.
 * Reset quiet, aligned fetch and the first fetch address.
 */
`timescale 1ns/100ps
`include "rv3_core_params.svh"

module rv3_core_sva (
    input logic          clk,
    input logic          rst_latch,
    input rv3_pkg::pc_t  imem_addr,
    input logic          dmem_we
);

    // Reset is synchronous, so its first edge still sees the old pipeline.
    reset_quiet: assert property (@(posedge clk) rst_latch && $past(rst_latch) |-> !dmem_we)
        else $error("data write strobe while reset is held");

    // Only aligned fetch.
    fetch_aligned: assert property (@(posedge clk) disable iff (rst_latch)
                                    imem_addr[1:0] == 2'b00)
        else $error("fetch address not word aligned");

    // First fetch after reset.
    entry_fetch: assert property (@(posedge clk) $fell(rst_latch) |->
                                  imem_addr == `RV3_ENTRY_PC)
        else $error("first fetch after reset not at the entry address");

endmodule

bind rv3_core rv3_core_sva u_sva (
    .clk(clk),
    .rst_latch(rst_latch),
    .imem_addr(imem_addr),
    .dmem_we(dmem_we)
);

// ==== tb_rv3_core.sv ====
/*
 * Testbench for the rv3 core.
 * Runs short directed programs from a ROM model and checks the data writes.
 */
`timescale 1ns/100ps
`include "rv3_core_params.svh"

module tb_rv3_core;

    localparam int ROM_WORDS = 64;
    // Six programs under 60 cycles each plus resets and margin.
    localparam int CYCLE_LIMIT = 2000;
    // Wait for one program's final store.
    localparam int RUN_LIMIT = 100;
    // Every program ends with a store to this address.
    localparam logic [11:0] DONE_OFF = 12'h7FC;
    localparam logic [31:0] NOP = 32'h0000_0013;

    logic                  clk;
    logic                  rst_latch;
    logic [31:0]           imem_addr;
    logic [`RV3_XLEN-1:0]  imem_rdata;
    logic                  dmem_we;
    logic [`RV3_XLEN-1:0]  dmem_addr;
    logic [`RV3_XLEN-1:0]  dmem_wdata;

    // Program ROM and the builder state.
    logic [31:0] rom [0:ROM_WORDS-1];
    logic [31:0] rom_idx;
    int          prog_len;
    logic [11:0] slot;

    // Observed and expected stores.
    logic [31:0] got_addr[$];
    logic [31:0] got_data[$];
    logic [31:0] exp_addr[$];
    logic [31:0] exp_data[$];
    logic        done_seen;
    int          reset_stores;
    int          test_errors;
    int          tests_passed;
    int          tests_failed;
    int          cycle_count;

    rv3_core u_dut (
        .clk(clk), .rst_latch(rst_latch),
        .imem_addr(imem_addr), .imem_rdata(imem_rdata),
        .dmem_we(dmem_we), .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata)
    );

    // Combinational instruction memory.
    assign rom_idx    = (imem_addr - `RV3_ENTRY_PC) >> 2;
    assign imem_rdata = (rom_idx < ROM_WORDS) ? rom[rom_idx] : NOP;

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // Watchdog on the whole run.
    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Run stopped after %0d cycles without finishing", cycle_count);
        $display("Something failed");
        $finish;
    end

    // Store monitor sampling mid-cycle.
    always @(negedge clk) begin
        if (dmem_we === 1'b1) begin
            if (rst_latch) begin
                reset_stores++;
            end else if (dmem_addr == {20'b0, DONE_OFF}) begin
                done_seen = 1'b1;
            end else begin
                got_addr.push_back(dmem_addr);
                got_data.push_back(dmem_wdata);
            end
        end
    end

    // RV32I encoders.
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] sw_insn(input logic [4:0] rs2, input logic [4:0] rs1,
                                            input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] lui_insn(input logic [4:0] rd, input logic [19:0] up);
        return {up, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] br_insn(input logic [2:0] f3, input logic [4:0] rs1,
                                            input logic [4:0] rs2, input int off);
        logic [12:0] o;
        o = off[12:0];
        return {o[12], o[10:5], rs2, rs1, f3, o[4:1], o[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jal_insn(input logic [4:0] rd, input int off);
        logic [20:0] o;
        o = off[20:0];
        return {o[20], o[10:1], o[11], o[19:12], rd, 7'b1101111};
    endfunction

    task automatic emit(input logic [31:0] insn);
        rom[prog_len] = insn;
        prog_len++;
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic store_word(input logic [4:0] rs2, input logic [11:0] off);
        emit(sw_insn(rs2, 5'd0, off));
    endtask

    // Loads a 32-bit constant with lui then addi.
    task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] upper;
        upper = value + 32'h800;
        emit(lui_insn(rd, upper[31:12]));
        emit(i_type(value[11:0], rd, 3'b000, rd));
    endtask

    // Result lands in x3 and goes to the next slot.
    task automatic op_and_store(input logic [31:0] insn, input logic [31:0] expected);
        emit(insn);
        store_word(5'd3, slot);
        expect_store({20'b0, slot}, expected);
        slot = slot + 12'd4;
    endtask

    // Holds the core in reset and clears the ROM and the records.
    task automatic begin_test();
        @(posedge clk);
        #2 rst_latch = 1'b1;
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = i_type(i[11:0], 5'd0, 3'b000, 5'd0);
        end
        prog_len = 0;
        slot     = 12'h400;
        got_addr.delete();
        got_data.delete();
        exp_addr.delete();
        exp_data.delete();
        done_seen    = 1'b0;
        reset_stores = 0;
        test_errors  = 0;
    endtask

    task automatic release_reset();
        emit(sw_insn(5'd0, 5'd0, DONE_OFF));
        repeat (4) @(posedge clk);
        #2 rst_latch = 1'b0;
    endtask

    task automatic wait_done(input string name);
        int waited;
        waited = 0;
        while (!done_seen && waited < RUN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        assert (done_seen) else begin
            $display("%s: program never reached its final store", name);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        int n;
        n = (got_data.size() < exp_data.size()) ? got_data.size() : exp_data.size();
        assert (got_data.size() == exp_data.size()) else begin
            $display("%s: wrong number of stores, %0d seen and %0d expected",
                     name, got_data.size(), exp_data.size());
            test_errors++;
        end
        for (int i = 0; i < n; i++) begin
            assert (got_addr[i] == exp_addr[i]) else begin
                $display("[FAIL] %s store %0d: dmem_addr = %h, expected %h",
                         name, i, got_addr[i], exp_addr[i]);
                test_errors++;
            end
            assert (got_data[i] == exp_data[i]) else begin
                $display("[FAIL] %s store %0d: dmem_wdata = %h, expected %h",
                         name, i, got_data[i], exp_data[i]);
                test_errors++;
            end
        end
        if (test_errors == 0) begin
            $display("%-16s passed, %0d stores", name, got_data.size());
            tests_passed++;
        end else begin
            $display("%-16s failed with %0d errors", name, test_errors);
            tests_failed++;
        end
    endtask

    task automatic run_and_check(input string name);
        release_reset();
        wait_done(name);
        finish_test(name);
    endtask

    task automatic reset_then_stores();
        begin_test();
        // First word is a store, so a valid bit left set in reset would leak it.
        store_word(5'd0, 12'h3FC);
        emit(i_type(12'h055, 5'd0, 3'b000, 5'd1));
        emit(i_type(12'h066, 5'd0, 3'b000, 5'd2));
        store_word(5'd1, 12'h400);
        store_word(5'd2, 12'h404);
        expect_store(32'h3FC, 32'h0);
        expect_store(32'h400, 32'h55);
        expect_store(32'h404, 32'h66);
        release_reset();
        @(negedge clk);
        assert (imem_addr == `RV3_ENTRY_PC) else begin
            $display("[FAIL] reset: imem_addr = %h, expected %h", imem_addr, `RV3_ENTRY_PC);
            test_errors++;
        end
        wait_done("reset");
        assert (reset_stores == 0) else begin
            $display("reset: a store strobe appeared while reset was held");
            test_errors++;
        end
        finish_test("reset");
    endtask

    task automatic alu_ops();
        logic [31:0] a, b, simm;
        logic [11:0] imm;
        logic [4:0]  sh;
        logic [19:0] up;
        begin_test();
        a    = $urandom;
        b    = $urandom;
        imm  = $urandom;
        sh   = $urandom;
        up   = $urandom;
        simm = {{20{imm[11]}}, imm};
        load_const(5'd1, a);
        load_const(5'd2, b);
        op_and_store(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), a + b);
        op_and_store(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd3), a - b);
        op_and_store(r_type(7'h00, 5'd2, 5'd1, 3'b001, 5'd3), a << b[4:0]);
        op_and_store(r_type(7'h00, 5'd2, 5'd1, 3'b010, 5'd3), {31'b0, $signed(a) < $signed(b)});
        op_and_store(r_type(7'h00, 5'd2, 5'd1, 3'b011, 5'd3), {31'b0, a < b});
        op_and_store(r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd3), a ^ b);
        op_and_store(r_type(7'h00, 5'd2, 5'd1, 3'b101, 5'd3), a >> b[4:0]);
        op_and_store(r_type(7'h20, 5'd2, 5'd1, 3'b101, 5'd3), $signed(a) >>> b[4:0]);
        op_and_store(r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd3), a | b);
        op_and_store(r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd3), a & b);
        // Immediate forms with a sign-extended operand.
        op_and_store(i_type(imm, 5'd1, 3'b000, 5'd3), a + simm);
        op_and_store(i_type(imm, 5'd1, 3'b010, 5'd3), {31'b0, $signed(a) < $signed(simm)});
        op_and_store(i_type(imm, 5'd1, 3'b011, 5'd3), {31'b0, a < simm});
        op_and_store(i_type(imm, 5'd1, 3'b100, 5'd3), a ^ simm);
        op_and_store(i_type(imm, 5'd1, 3'b110, 5'd3), a | simm);
        op_and_store(i_type(imm, 5'd1, 3'b111, 5'd3), a & simm);
        op_and_store(i_type({7'h00, sh}, 5'd1, 3'b001, 5'd3), a << sh);
        op_and_store(i_type({7'h00, sh}, 5'd1, 3'b101, 5'd3), a >> sh);
        op_and_store(i_type({7'h20, sh}, 5'd1, 3'b101, 5'd3), $signed(a) >>> sh);
        op_and_store(lui_insn(5'd3, up), {up, 12'h000});
        run_and_check("alu");
    endtask

    task automatic dependent_adds();
        logic [31:0] r, v2, v3, v4, v5;
        begin_test();
        r  = $urandom;
        v2 = r + 32'd17;
        v3 = v2 + r;
        v4 = v3 + v2;
        v5 = v4 - r;
        load_const(5'd1, r);
        // Each result feeds the next instruction.
        emit(i_type(12'd17, 5'd1, 3'b000, 5'd2));
        emit(r_type(7'h00, 5'd1, 5'd2, 3'b000, 5'd3));
        emit(r_type(7'h00, 5'd2, 5'd3, 3'b000, 5'd4));
        emit(r_type(7'h20, 5'd1, 5'd4, 3'b000, 5'd5));
        store_word(5'd5, 12'h400);
        // Write to x0 is dropped.
        emit(i_type(12'd5, 5'd1, 3'b000, 5'd0));
        store_word(5'd0, 12'h404);
        expect_store(32'h400, v5);
        expect_store(32'h404, 32'h0);
        run_and_check("forwarding");
    endtask

    task automatic forward_branches();
        begin_test();
        emit(i_type(12'd5, 5'd0, 3'b000, 5'd1));
        emit(i_type(12'd5, 5'd0, 3'b000, 5'd2));
        emit(i_type(12'h011, 5'd0, 3'b000, 5'd3));
        emit(i_type(12'h022, 5'd0, 3'b000, 5'd4));
        // Taken beq that is guessed not taken.
        emit(br_insn(3'b000, 5'd1, 5'd2, 12));
        store_word(5'd3, 12'h400);
        store_word(5'd3, 12'h404);
        store_word(5'd4, 12'h408);
        // Not-taken bne keeps its fall-through.
        emit(br_insn(3'b001, 5'd1, 5'd2, 8));
        store_word(5'd4, 12'h40C);
        store_word(5'd3, 12'h410);
        emit(i_type(12'hFFF, 5'd0, 3'b000, 5'd5));
        emit(i_type(12'h001, 5'd0, 3'b000, 5'd6));
        // Unsigned 1 < 0xffffffff is taken.
        emit(br_insn(3'b110, 5'd6, 5'd5, 8));
        store_word(5'd3, 12'h414);
        // Signed -1 >= 1 fails.
        emit(br_insn(3'b101, 5'd5, 5'd6, 8));
        store_word(5'd4, 12'h418);
        expect_store(32'h408, 32'h22);
        expect_store(32'h40C, 32'h22);
        expect_store(32'h410, 32'h11);
        expect_store(32'h418, 32'h22);
        run_and_check("forward branch");
    endtask

    task automatic backward_loop();
        int k;
        begin_test();
        k = 3 + $urandom % 4;
        emit(i_type(12'd0, 5'd0, 3'b000, 5'd1));
        emit(i_type(k[11:0], 5'd0, 3'b000, 5'd2));
        emit(i_type(12'h400, 5'd0, 3'b000, 5'd3));
        // Body stores the counter through a moving pointer.
        emit(i_type(12'd1, 5'd1, 3'b000, 5'd1));
        emit(sw_insn(5'd1, 5'd3, 12'd0));
        emit(i_type(12'd4, 5'd3, 3'b000, 5'd3));
        emit(br_insn(3'b100, 5'd1, 5'd2, -12));
        for (int i = 1; i <= k; i++) begin
            expect_store(32'h400 + 4 * (i - 1), i);
        end
        run_and_check("backward loop");
    endtask

    task automatic jal_link();
        int jal_idx;
        begin_test();
        emit(i_type(12'h077, 5'd0, 3'b000, 5'd2));
        jal_idx = prog_len;
        emit(jal_insn(5'd1, 8));
        store_word(5'd2, 12'h404);
        store_word(5'd1, 12'h400);
        expect_store(32'h400, `RV3_ENTRY_PC + 4 * jal_idx + 4);
        run_and_check("jal");
    endtask

    initial begin
        rst_latch    = 1'b1;
        tests_passed = 0;
        tests_failed = 0;
        prog_len     = 0;
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = NOP;
        end
        void'($urandom(32'h7020));
        reset_then_stores();
        alu_ops();
        dependent_adds();
        forward_branches();
        backward_loop();
        jal_link();
        $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== rv3_core.f ====
+incdir+.
rv3_pkg.sv
rv3_fetch.sv
rv3_regfile.sv
rv3_decode.sv
rv3_execute.sv
rv3_core.sv
rv3_core_sva.sv
tb_rv3_core.sv

// ==== Bender.yml ====
package:
  name: rv3_core

export_include_dirs:
  - .

sources:
  # Core RTL in compile order.
  - include_dirs:
      - .
    files:
      - rv3_pkg.sv
      - rv3_fetch.sv
      - rv3_regfile.sv
      - rv3_decode.sv
      - rv3_execute.sv
      - rv3_core.sv
  # Testbench and bound assertions.
  - target: test
    include_dirs:
      - .
    files:
      - rv3_core_sva.sv
      - tb_rv3_core.sv
